// File: mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // Host bus geometry
  localparam int host_addr_w = 14;
  localparam int host_data_w = 16;

  // Controller register index taken from the low address bits
  localparam int ctl_addr_w = 8;

  // Bank select carried on the host bus
  typedef enum logic [1:0] {
    bank_ctl   = 2'd0,
    bank_mod   = 2'd1,
    bank_delay = 2'd2,
    bank_rsvd  = 2'd3
  } bank_sel_e;

  // Segment the host writes into
  localparam logic [ctl_addr_w-1:0] addr_mod_wr_segment = 8'h20;

  // Segment the player reads from
  localparam logic [ctl_addr_w-1:0] addr_mod_rd_segment = 8'h21;

  // Last modulation index before wrap
  localparam logic [ctl_addr_w-1:0] addr_mod_cycle = 8'h22;

  // bus_clk cycles per step, minus one
  localparam logic [ctl_addr_w-1:0] addr_mod_freq_div = 8'h23;

  // Run bit in data bit 0
  localparam logic [ctl_addr_w-1:0] addr_mod_start = 8'h24;

endpackage

`default_nettype wire

// File: drive_pkg.sv
`default_nettype none

package drive_pkg;

  localparam int mod_addr_w  = 10;
  localparam int mod_data_w  = 8;
  localparam int delay_idx_w = 6;
  localparam int freq_div_w  = 16;

  // Decoded control values consumed by the player
  typedef struct packed {
    logic                  run;
    logic                  rd_segment;
    logic [mod_addr_w-1:0] cycle;
    logic [freq_div_w-1:0] freq_div;
  } ctl_regs_t;

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_emit
  } player_state_e;

endpackage

`default_nettype wire

// File: host_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface host_bus_if;
  import mem_map_pkg::*;

  logic                   en;
  logic                   we;
  bank_sel_e              select;
  logic [host_addr_w-1:0] addr;
  logic [host_data_w-1:0] data_in;
  logic [host_data_w-1:0] data_out;
  // ctl, delay, mod segment 0, mod segment 1
  logic [3:0]             enables;

  modport decoder (
    input  en, we, select, addr, data_in,
    output data_out, enables
  );

  modport host (
    output en, we, select, addr, data_in,
    input  data_out, enables
  );

endinterface

`default_nettype wire

// File: dual_port_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
  parameter int depth = 256,
  parameter int width = 16
) (
  input  var logic                     bus_clk,
  input  var logic                     a_en,
  input  var logic                     a_we,
  input  var logic [$clog2(depth)-1:0] a_addr,
  input  var logic [width-1:0]         a_din,
  output logic     [width-1:0]         a_dout,
  input  var logic [$clog2(depth)-1:0] b_addr,
  output logic     [width-1:0]         b_dout
);

  logic [width-1:0] mem [depth];

  // Write-first port a so a write also shows on a_dout
  always_ff @(posedge bus_clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_din;
        a_dout      <= a_din;
      end else begin
        a_dout <= mem[a_addr];
      end
    end
  end

  // Port b reads every cycle
  always_ff @(posedge bus_clk) begin
    b_dout <= mem[b_addr];
  end

endmodule

`default_nettype wire

// File: memory_map.sv
`timescale 1ns/1ns
`default_nettype none

module memory_map #(
  parameter int mod_depth   = 1024,
  parameter int delay_depth = 64
) (
  input  var logic                                 bus_clk,
  input  var logic                                 rst_n,
  host_bus_if.decoder                              host,
  input  var logic [drive_pkg::delay_idx_w-1:0]    delay_idx,
  output logic     [mem_map_pkg::host_data_w-1:0]  delay_value,
  input  var logic [drive_pkg::mod_addr_w-1:0]     mod_idx,
  input  var logic                                 mod_segment,
  output logic     [drive_pkg::mod_data_w-1:0]     mod_value,
  output drive_pkg::ctl_regs_t                     ctl_regs
);
  import mem_map_pkg::*;
  import drive_pkg::*;

  localparam int ctl_depth = 2 ** ctl_addr_w;
  localparam int mod_aw    = $clog2(mod_depth);
  localparam int dly_aw    = $clog2(delay_depth);

  logic                   ctl_en;
  logic                   dly_en;
  logic                   mod_en_0;
  logic                   mod_en_1;
  logic [ctl_addr_w-1:0]  ctl_addr;
  logic [2:0]             ctl_we_hist;
  logic                   ctl_capture;
  logic                   ctl_rd_seen;
  logic [host_data_w-1:0] ctl_dout;
  logic                   mod_wr_segment;
  logic                   mod_segment_q;
  logic [mod_data_w-1:0]  mod_value_0;
  logic [mod_data_w-1:0]  mod_value_1;

  // Bank decode
  assign ctl_addr = host.addr[ctl_addr_w-1:0];
  assign ctl_en   = host.en & (host.select == bank_ctl);
  assign dly_en   = host.en & (host.select == bank_delay);
  assign mod_en_0 = host.en & (host.select == bank_mod) & ~mod_wr_segment;
  assign mod_en_1 = host.en & (host.select == bank_mod) & mod_wr_segment;

  assign host.enables = {ctl_en, dly_en, mod_en_0, mod_en_1};

  // Strobe held for exactly two cycles, seen on the third
  assign ctl_capture = (ctl_we_hist == 3'b011);

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctl_we_hist    <= '0;
      ctl_rd_seen    <= 1'b0;
      mod_wr_segment <= 1'b0;
      mod_segment_q  <= 1'b0;
      ctl_regs       <= '0;
    end else begin
      ctl_we_hist   <= {ctl_we_hist[1:0], ctl_en & host.we};
      mod_segment_q <= mod_segment;
      if (ctl_en) begin
        ctl_rd_seen <= 1'b1;
      end
      if (ctl_capture) begin
        case (ctl_addr)
          addr_mod_wr_segment: mod_wr_segment      <= host.data_in[0];
          addr_mod_rd_segment: ctl_regs.rd_segment <= host.data_in[0];
          addr_mod_cycle:      ctl_regs.cycle      <= host.data_in[mod_addr_w-1:0];
          addr_mod_freq_div:   ctl_regs.freq_div   <= host.data_in;
          addr_mod_start:      ctl_regs.run        <= host.data_in[0];
          default: begin
          end
        endcase
      end
    end
  end

  // Read data stays zero until the first controller access
  assign host.data_out = ctl_rd_seen ? ctl_dout : '0;

  // Controller bank with port b kept for the drive counters
  dual_port_ram #(.depth(ctl_depth), .width(host_data_w)) i_ctl_ram (
    .bus_clk (bus_clk),
    .a_en    (ctl_en | ctl_capture),
    .a_we    (ctl_capture),
    .a_addr  (ctl_addr),
    .a_din   (host.data_in),
    .a_dout  (ctl_dout),
    .b_addr  ('0),
    .b_dout  ()
  );

  dual_port_ram #(.depth(delay_depth), .width(host_data_w)) i_delay_ram (
    .bus_clk (bus_clk),
    .a_en    (dly_en),
    .a_we    (host.we),
    .a_addr  (host.addr[dly_aw-1:0]),
    .a_din   (host.data_in),
    .a_dout  (),
    .b_addr  (delay_idx[dly_aw-1:0]),
    .b_dout  (delay_value)
  );

  // Double-buffered modulation segments
  dual_port_ram #(.depth(mod_depth), .width(mod_data_w)) i_mod_ram_0 (
    .bus_clk (bus_clk),
    .a_en    (mod_en_0),
    .a_we    (host.we),
    .a_addr  (host.addr[mod_aw-1:0]),
    .a_din   (host.data_in[mod_data_w-1:0]),
    .a_dout  (),
    .b_addr  (mod_idx[mod_aw-1:0]),
    .b_dout  (mod_value_0)
  );

  dual_port_ram #(.depth(mod_depth), .width(mod_data_w)) i_mod_ram_1 (
    .bus_clk (bus_clk),
    .a_en    (mod_en_1),
    .a_we    (host.we),
    .a_addr  (host.addr[mod_aw-1:0]),
    .a_din   (host.data_in[mod_data_w-1:0]),
    .a_dout  (),
    .b_addr  (mod_idx[mod_aw-1:0]),
    .b_dout  (mod_value_1)
  );

  // Segment select delayed to match the RAM read latency
  assign mod_value = mod_segment_q ? mod_value_1 : mod_value_0;

endmodule

`default_nettype wire

// File: modulation_player.sv
`timescale 1ns/1ns
`default_nettype none

module modulation_player (
  input  var logic                              bus_clk,
  input  var logic                              rst_n,
  input  var drive_pkg::ctl_regs_t              ctl_regs,
  output logic     [drive_pkg::mod_addr_w-1:0]  mod_idx,
  output logic                                  mod_segment,
  input  var logic [drive_pkg::mod_data_w-1:0]  mod_value,
  output logic     [drive_pkg::mod_data_w-1:0]  sample_value,
  output logic                                  sample_valid
);
  import drive_pkg::*;

  player_state_e         state;
  logic [mod_addr_w-1:0] idx;
  logic [freq_div_w-1:0] wait_cnt;
  logic                  issue;
  logic                  issue_q;

  // Index goes out on the emit cycle
  assign issue       = (state == st_emit);
  assign mod_idx     = idx;
  assign mod_segment = ctl_regs.rd_segment;

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      idx      <= '0;
      wait_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          idx <= '0;
          if (ctl_regs.run) begin
            state <= st_emit;
          end
        end
        st_emit: begin
          idx      <= (idx == ctl_regs.cycle) ? '0 : idx + 1'b1;
          wait_cnt <= ctl_regs.freq_div;
          // Zero divider means back-to-back steps
          if (ctl_regs.freq_div != '0) begin
            state <= st_wait;
          end else if (!ctl_regs.run) begin
            state <= st_idle;
          end
        end
        st_wait: begin
          wait_cnt <= wait_cnt - 1'b1;
          if (wait_cnt == freq_div_w'(1)) begin
            state <= ctl_regs.run ? st_emit : st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // RAM read stage followed by the sample register stage
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_q      <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      issue_q      <= issue;
      sample_valid <= issue_q;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (issue_q) begin
      sample_value <= mod_value;
    end
  end

endmodule

`default_nettype wire

// File: memory_top.sv
`timescale 1ns/1ns
`default_nettype none

module memory_top #(
  parameter int mod_depth   = 1024,
  parameter int delay_depth = 64
) (
  input  var logic                                 bus_clk,
  input  var logic                                 rst_n,
  input  var logic                                 host_en,
  input  var logic                                 host_we,
  input  var mem_map_pkg::bank_sel_e               host_select,
  input  var logic [mem_map_pkg::host_addr_w-1:0]  host_addr,
  input  var logic [mem_map_pkg::host_data_w-1:0]  host_data_in,
  output logic     [mem_map_pkg::host_data_w-1:0]  host_data_out,
  output logic     [3:0]                           host_enables,
  input  var logic [drive_pkg::delay_idx_w-1:0]    delay_idx,
  output logic     [mem_map_pkg::host_data_w-1:0]  delay_value,
  output logic     [drive_pkg::mod_data_w-1:0]     sample_value,
  output logic                                     sample_valid
);
  import drive_pkg::*;

  ctl_regs_t             ctl_regs;
  logic [mod_addr_w-1:0] mod_idx;
  logic                  mod_segment;
  logic [mod_data_w-1:0] mod_value;

  host_bus_if host_bus ();

  assign host_bus.en      = host_en;
  assign host_bus.we      = host_we;
  assign host_bus.select  = host_select;
  assign host_bus.addr    = host_addr;
  assign host_bus.data_in = host_data_in;
  assign host_data_out    = host_bus.data_out;
  assign host_enables     = host_bus.enables;

  memory_map #(.mod_depth(mod_depth), .delay_depth(delay_depth)) i_memory_map (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .host        (host_bus.decoder),
    .delay_idx   (delay_idx),
    .delay_value (delay_value),
    .mod_idx     (mod_idx),
    .mod_segment (mod_segment),
    .mod_value   (mod_value),
    .ctl_regs    (ctl_regs)
  );

  modulation_player i_player (
    .bus_clk      (bus_clk),
    .rst_n        (rst_n),
    .ctl_regs     (ctl_regs),
    .mod_idx      (mod_idx),
    .mod_segment  (mod_segment),
    .mod_value    (mod_value),
    .sample_value (sample_value),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

// File: memory_props.sv
`timescale 1ns/1ns
`default_nettype none

module memory_props (
  input var logic       bus_clk,
  input var logic       rst_n,
  input var logic       host_en,
  input var logic [3:0] host_enables,
  input var logic       sample_valid
);

  // Only one bank decoded per access
  a_one_bank: assert property (@(posedge bus_clk) disable iff (!rst_n)
    $onehot0(host_enables))
    else $error("more than one bank enable high: %b", host_enables);

  // Enables follow the host strobe
  a_en_needed: assert property (@(posedge bus_clk) disable iff (!rst_n)
    !host_en |-> (host_enables == 4'b0000))
    else $error("bank enable high without host en: %b", host_enables);

  // Samples are single-cycle pulses
  a_valid_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
    sample_valid |=> !sample_valid)
    else $error("sample_valid high for two cycles");

endmodule

bind memory_top memory_props i_props (
  .bus_clk      (bus_clk),
  .rst_n        (rst_n),
  .host_en      (host_en),
  .host_enables (host_enables),
  .sample_valid (sample_valid)
);

`default_nettype wire

// File: tb_memory_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_memory_top;
  import mem_map_pkg::*;
  import drive_pkg::*;

  typedef enum {op_wr, op_wr_short, op_rd, op_dly, op_play} op_e;

  typedef struct {
    string       name;
    op_e         op;
    bank_sel_e   bank;
    logic [13:0] addr;
    logic [15:0] data;
    logic [15:0] exp_val;
  } step_t;

  logic                   bus_clk;
  logic                   rst_n;
  logic                   host_en;
  logic                   host_we;
  bank_sel_e              host_select;
  logic [host_addr_w-1:0] host_addr;
  logic [host_data_w-1:0] host_data_in;
  logic [host_data_w-1:0] host_data_out;
  logic [3:0]             host_enables;
  logic [delay_idx_w-1:0] delay_idx;
  logic [host_data_w-1:0] delay_value;
  logic [mod_data_w-1:0]  sample_value;
  logic                   sample_valid;

  step_t                 steps[$];
  integer                seed = 32'h27cb_01d1;
  int                    errors;
  int                    play_samples;
  int                    watchdog_cycles;
  bit                    built;
  // Expected view of the write page and player settings
  logic                  model_wr_seg;
  logic                  model_rd_seg;
  logic [mod_addr_w-1:0] model_cycle;
  logic [15:0]           model_freq_div;
  logic [mod_data_w-1:0] mod_model [2][1024];

  memory_top #(.mod_depth(1024), .delay_depth(64)) i_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  function automatic void add_step(input string name, input op_e op, input bank_sel_e bank,
                                   input logic [13:0] addr, input logic [15:0] data,
                                   input logic [15:0] exp_val);
    step_t s;
    s.name    = name;
    s.op      = op;
    s.bank    = bank;
    s.addr    = addr;
    s.data    = data;
    s.exp_val = exp_val;
    steps.push_back(s);
    if (op == op_play) begin
      play_samples += int'(data);
    end
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp_val,
                             input logic [15:0] act);
    if (act !== exp_val) begin
      $display("[FAIL] %s expected %h actual %h", name, exp_val, act);
      errors++;
    end
  endtask

  function automatic logic [3:0] expected_enables(input bank_sel_e bank);
    case (bank)
      bank_ctl:   return 4'b1000;
      bank_delay: return 4'b0100;
      bank_mod:   return model_wr_seg ? 4'b0001 : 4'b0010;
      default:    return 4'b0000;
    endcase
  endfunction

  task automatic build_steps();
    logic [15:0] vals [4];
    logic [13:0] didx [4];
    logic [7:0]  ramp;
    for (int k = 0; k < 4; k++) begin
      vals[k] = 16'($random(seed));
      add_step("ctl_wr", op_wr, bank_ctl, 14'(k), vals[k], 16'h0);
    end
    for (int k = 0; k < 4; k++) begin
      add_step("ctl_rd", op_rd, bank_ctl, 14'(k), 16'h0, vals[k]);
    end
    // One random index in each quarter of the table keeps them distinct
    for (int k = 0; k < 4; k++) begin
      didx[k] = 14'(k * 16 + ($random(seed) & 15));
      vals[k] = 16'($random(seed));
      add_step("delay_wr", op_wr, bank_delay, didx[k], vals[k], 16'h0);
    end
    for (int k = 0; k < 4; k++) begin
      add_step("delay_rd", op_dly, bank_delay, didx[k], 16'h0, vals[k]);
    end
    add_step("cfg_cycle", op_wr, bank_ctl, 14'(addr_mod_cycle), 16'd5, 16'h0);
    add_step("cfg_div", op_wr, bank_ctl, 14'(addr_mod_freq_div), 16'd3, 16'h0);
    add_step("cfg_wr_seg", op_wr, bank_ctl, 14'(addr_mod_wr_segment), 16'd0, 16'h0);
    for (int i = 0; i <= 5; i++) begin
      ramp = 8'(i * 8 + 4);
      add_step("ramp_wr", op_wr, bank_mod, 14'(i), {8'h00, ramp}, 16'h0);
    end
    add_step("cfg_wr_seg", op_wr, bank_ctl, 14'(addr_mod_wr_segment), 16'd1, 16'h0);
    for (int i = 0; i <= 5; i++) begin
      ramp = 8'(i * 8 + 4) ^ 8'hff;
      add_step("inv_wr", op_wr, bank_mod, 14'(i), {8'h00, ramp}, 16'h0);
    end
    add_step("cfg_rd_seg", op_wr, bank_ctl, 14'(addr_mod_rd_segment), 16'd0, 16'h0);
    add_step("run_on", op_wr, bank_ctl, 14'(addr_mod_start), 16'd1, 16'h0);
    add_step("play_seg0", op_play, bank_ctl, 14'h0, 16'd14, 16'h0);
    add_step("run_off", op_wr, bank_ctl, 14'(addr_mod_start), 16'd0, 16'h0);
    add_step("cfg_rd_seg", op_wr, bank_ctl, 14'(addr_mod_rd_segment), 16'd1, 16'h0);
    add_step("run_on", op_wr, bank_ctl, 14'(addr_mod_start), 16'd1, 16'h0);
    add_step("play_seg1", op_play, bank_ctl, 14'h0, 16'd14, 16'h0);
    add_step("run_off", op_wr, bank_ctl, 14'(addr_mod_start), 16'd0, 16'h0);
    // Single-cycle strobe must leave segment 1 selected
    add_step("short_wr", op_wr_short, bank_ctl, 14'(addr_mod_rd_segment), 16'd0, 16'h0);
    add_step("short_rd", op_rd, bank_ctl, 14'(addr_mod_rd_segment), 16'h0, 16'd1);
    add_step("run_on", op_wr, bank_ctl, 14'(addr_mod_start), 16'd1, 16'h0);
    add_step("play_short", op_play, bank_ctl, 14'h0, 16'd8, 16'h0);
    add_step("run_off", op_wr, bank_ctl, 14'(addr_mod_start), 16'd0, 16'h0);
  endtask

  task automatic update_model(input step_t s);
    if (s.bank == bank_mod) begin
      mod_model[model_wr_seg][s.addr[mod_addr_w-1:0]] = s.data[mod_data_w-1:0];
    end else if (s.bank == bank_ctl) begin
      case (s.addr[ctl_addr_w-1:0])
        addr_mod_wr_segment: model_wr_seg   = s.data[0];
        addr_mod_rd_segment: model_rd_seg   = s.data[0];
        addr_mod_cycle:      model_cycle    = s.data[mod_addr_w-1:0];
        addr_mod_freq_div:   model_freq_div = s.data;
        default: begin
        end
      endcase
    end
  endtask

  // Holds the strobe for the given cycles, then drops it on the last edge
  task automatic host_access(input step_t s, input logic we, input int cycles);
    @(posedge bus_clk);
    host_en      <= 1'b1;
    host_we      <= we;
    host_select  <= s.bank;
    host_addr    <= s.addr;
    host_data_in <= s.data;
    for (int c = 0; c < cycles; c++) begin
      @(negedge bus_clk);
      check_value({s.name, " enables"}, 16'(expected_enables(s.bank)), 16'(host_enables));
      @(posedge bus_clk);
    end
    host_en <= 1'b0;
    host_we <= 1'b0;
  endtask

  task automatic play_check(input string name, input int count);
    int idx;
    int wait_cycles;
    int cycle_now;
    int last_pulse;
    idx        = 0;
    cycle_now  = 0;
    last_pulse = -1;
    for (int n = 0; n < count; n++) begin
      wait_cycles = 0;
      do begin
        @(negedge bus_clk);
        cycle_now++;
        wait_cycles++;
      end while (!sample_valid && wait_cycles < 64);
      if (!sample_valid) begin
        $display("%s: no sample_valid pulse within %0d cycles", name, wait_cycles);
        errors++;
        return;
      end
      check_value(name, 16'(mod_model[model_rd_seg][idx]), 16'(sample_value));
      if (last_pulse >= 0) begin
        check_value({name, " spacing"}, model_freq_div + 16'd1, 16'(cycle_now - last_pulse));
      end
      last_pulse = cycle_now;
      idx = (idx == int'(model_cycle)) ? 0 : idx + 1;
    end
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      op_wr:       host_access(s, 1'b1, (s.bank == bank_ctl) ? 3 : 1);
      op_wr_short: host_access(s, 1'b1, 1);
      op_rd: begin
        host_access(s, 1'b0, 1);
        @(negedge bus_clk);
        check_value(s.name, s.exp_val, host_data_out);
      end
      op_dly: begin
        @(posedge bus_clk);
        delay_idx <= s.addr[delay_idx_w-1:0];
        @(posedge bus_clk);
        @(negedge bus_clk);
        check_value(s.name, s.exp_val, delay_value);
      end
      op_play: play_check(s.name, int'(s.data));
    endcase
    if (s.op == op_wr) begin
      update_model(s);
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    host_en        = 1'b0;
    host_we        = 1'b0;
    host_select    = bank_ctl;
    host_addr      = '0;
    host_data_in   = '0;
    delay_idx      = '0;
    errors         = 0;
    play_samples   = 0;
    model_wr_seg   = 1'b0;
    model_rd_seg   = 1'b0;
    model_cycle    = '0;
    model_freq_div = '0;
    build_steps();
    watchdog_cycles = steps.size() * 40 + play_samples * 8 + 100;
    built = 1'b1;
    repeat (2) @(posedge bus_clk);
    rst_n <= 1'b1;
    // Quiet outputs after reset
    for (int c = 0; c < 20; c++) begin
      @(negedge bus_clk);
      check_value("reset enables", 16'h0, 16'(host_enables));
      check_value("reset sample_valid", 16'h0, 16'(sample_valid));
    end
    check_value("reset data_out", 16'h0, host_data_out);
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    repeat (4) @(posedge bus_clk);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    wait (built);
    repeat (watchdog_cycles) @(posedge bus_clk);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
mem_map_pkg.sv
drive_pkg.sv
host_bus_if.sv
dual_port_ram.sv
memory_map.sv
modulation_player.sv
memory_top.sv
memory_props.sv
tb_memory_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_memory_top --Mdir obj_dir -o sim_memory_top -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_memory_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
